// ==== all.f ====
+incdir+include
source/rob_types_pkg.sv
source/rob_msg_pkg.sv
source/rob_ptr_ctrl.sv
source/rob_entry_array.sv
source/rob_commit_fsm.sv
source/rob_top.sv
test/rob_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the reorder buffer testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module rob_tb -Mdir obj_dir -f all.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vrob_tb > "$log" 2>&1
sim_status=$?
cat "$log"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "RESULT: PASS" "$log"; then
    exit 0
fi
echo "pass message not found in $log"
exit 1

// ==== source/rob_commit_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module rob_commit_fsm
    import rob_types_pkg::*;
    import rob_msg_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst_n,
    input  wire tag_t       head,
    input  wire logic       head_valid,
    input  wire rob_entry_t head_entry,
    input  wire logic       store_ack,
    output logic            pop,
    output logic            flush,
    output logic            alloc_block,
    output logic            retire_valid,
    output rob_retire_t     retire,
    output logic            store_release_valid,
    output tag_t            store_tag,
    output logic            redirect_valid,
    output addr_t           redirect_pc
);

    rob_state_t state_q;
    rob_state_t state_d;

    logic head_ready;
    logic mispredict;

    assign head_ready = head_valid && head_entry.done;
    assign mispredict = head_entry.pred_taken != head_entry.actual_taken;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ST_RUN;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d             = state_q;
        pop                 = 1'b0;
        flush               = 1'b0;
        alloc_block         = 1'b0;
        retire_valid        = 1'b0;
        store_release_valid = 1'b0;
        redirect_valid      = 1'b0;

        case (state_q)
            ST_RUN: begin
                if (head_ready) begin
                    if (head_entry.is_store) begin
                        // hand the store over, keep it at the head until acked
                        store_release_valid = 1'b1;
                        state_d             = ST_STORE_WAIT;
                    end else if (mispredict) begin
                        retire_valid   = 1'b1;
                        redirect_valid = 1'b1;
                        pop            = 1'b1;
                        state_d        = ST_FLUSH;
                    end else begin
                        retire_valid = 1'b1;
                        pop          = 1'b1;
                    end
                end
            end

            ST_STORE_WAIT: begin
                if (store_ack) begin
                    pop     = 1'b1;
                    state_d = ST_RUN;
                end
            end

            ST_FLUSH: begin
                // one cycle, drops everything younger than the branch
                flush       = 1'b1;
                alloc_block = 1'b1;
                state_d     = ST_RUN;
            end

            default: begin
                state_d = ST_RUN;
            end
        endcase
    end

    // payload follows the head slot, qualified by the strobes
    assign retire.tag  = head;
    assign retire.rd   = head_entry.rd;
    assign retire.data = head_entry.data;
    assign store_tag   = head;
    assign redirect_pc = head_entry.target;

    a_ack_in_wait: assert property (@(posedge clk) disable iff (!rst_n)
        store_ack |-> state_q == ST_STORE_WAIT);

endmodule

`default_nettype wire

// ==== source/rob_entry_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module rob_entry_array
    import rob_types_pkg::*;
    import rob_msg_pkg::*;
#(
    parameter int ROB_DEPTH = 16
) (
    input  wire logic          clk,
    input  wire logic          rst_n,
    input  wire logic          alloc_we,
    input  wire tag_t          alloc_tag,
    input  wire rob_alloc_t    alloc,
    input  wire logic          complete_valid,
    input  wire rob_complete_t complete,
    input  wire tag_t          head,
    input  wire logic          pop,
    input  wire logic          flush,
    output rob_entry_t         head_entry,
    output logic               head_valid
);

    localparam int IDX_W = $clog2(ROB_DEPTH);

    logic [ROB_DEPTH-1:0] valid_q;
    rob_entry_t           entries [ROB_DEPTH];

    logic [IDX_W-1:0] alloc_idx;
    logic [IDX_W-1:0] cmp_idx;
    logic [IDX_W-1:0] head_idx;

    assign alloc_idx = alloc_tag[IDX_W-1:0];
    assign cmp_idx   = complete.tag[IDX_W-1:0];
    assign head_idx  = head[IDX_W-1:0];

    // live slot bits
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (flush) begin
            valid_q <= '0;
        end else begin
            if (pop) begin
                valid_q[head_idx] <= 1'b0;
            end
            if (alloc_we) begin
                valid_q[alloc_idx] <= 1'b1;
            end
        end
    end

    // payload storage
    always_ff @(posedge clk) begin
        if (alloc_we) begin
            entries[alloc_idx].done       <= 1'b0;
            entries[alloc_idx].is_store   <= alloc.is_store;
            entries[alloc_idx].pred_taken <= alloc.pred_taken;
            entries[alloc_idx].rd         <= alloc.rd;
        end
        // result fields arrive later, from execute or the store buffer
        if (complete_valid) begin
            entries[cmp_idx].done         <= 1'b1;
            entries[cmp_idx].data         <= complete.data;
            entries[cmp_idx].actual_taken <= complete.actual_taken;
            entries[cmp_idx].target       <= complete.target;
        end
    end

    assign head_valid = valid_q[head_idx];
    assign head_entry = entries[head_idx];

    // completions must name a slot that is still in flight
    a_complete_live: assert property (@(posedge clk) disable iff (!rst_n)
        complete_valid |-> (int'(complete.tag) < ROB_DEPTH) && valid_q[cmp_idx]);

endmodule

`default_nettype wire

// ==== source/rob_msg_pkg.sv ====
`default_nettype none

package rob_msg_pkg;

    import rob_types_pkg::*;

    // from decode, in program order
    typedef struct packed {
        reg_name_t rd;
        logic      is_store;
        logic      pred_taken;
    } rob_alloc_t;

    // from execution or the store buffer, any order
    typedef struct packed {
        tag_t  tag;
        data_t data;
        logic  actual_taken;
        addr_t target;
    } rob_complete_t;

    // head slot as seen by the commit FSM
    typedef struct packed {
        logic      done;
        logic      is_store;
        logic      pred_taken;
        logic      actual_taken;
        reg_name_t rd;
        data_t     data;
        addr_t     target;
    } rob_entry_t;

    // register file write on retire
    typedef struct packed {
        tag_t      tag;
        reg_name_t rd;
        data_t     data;
    } rob_retire_t;

endpackage

`default_nettype wire

// ==== source/rob_ptr_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module rob_ptr_ctrl
    import rob_types_pkg::*;
#(
    parameter int ROB_DEPTH = 16
) (
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire logic alloc_valid,
    input  wire logic alloc_block,
    input  wire logic pop,
    input  wire logic flush,
    output logic      alloc_ack,
    output tag_t      head,
    output tag_t      tail,
    output logic      full,
    output logic      empty
);

    localparam int CNT_W = $clog2(ROB_DEPTH) + 1;

    tag_t             head_q;
    tag_t             tail_q;
    logic [CNT_W-1:0] count_q;

    // pointers wrap at the configured depth, not at the tag width
    function automatic tag_t ptr_inc(input tag_t ptr);
        if (ptr == tag_t'(ROB_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 5'd1;
    endfunction

    assign full      = (count_q == CNT_W'(ROB_DEPTH));
    assign empty     = (count_q == '0);
    assign alloc_ack = alloc_valid && !full && !alloc_block;
    assign head      = head_q;
    assign tail      = tail_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else if (flush) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (alloc_ack) begin
                tail_q <= ptr_inc(tail_q);
            end
            if (pop) begin
                head_q <= ptr_inc(head_q);
            end
            // alloc and pop together leave the count alone
            if (alloc_ack && !pop) begin
                count_q <= count_q + CNT_W'(1);
            end else if (pop && !alloc_ack) begin
                count_q <= count_q - CNT_W'(1);
            end
        end
    end

    a_count_bound: assert property (@(posedge clk) disable iff (!rst_n)
        count_q <= CNT_W'(ROB_DEPTH));

    a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
        pop |-> !empty);

endmodule

`default_nettype wire

// ==== source/rob_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module rob_top
    import rob_types_pkg::*;
    import rob_msg_pkg::*;
#(
    parameter int ROB_DEPTH = 16
) (
    input  wire logic          clk,
    input  wire logic          rst_n,
    input  wire logic          alloc_valid,
    input  wire rob_alloc_t    alloc,
    output logic               alloc_ack,
    output tag_t               alloc_tag,
    output logic               full,
    input  wire logic          complete_valid,
    input  wire rob_complete_t complete,
    input  wire logic          store_ack,
    output logic               retire_valid,
    output rob_retire_t        retire,
    output logic               store_release_valid,
    output tag_t               store_tag,
    output logic               redirect_valid,
    output addr_t              redirect_pc
);

    tag_t       head;
    logic       pop;
    logic       flush;
    logic       alloc_block;
    logic       head_valid;
    rob_entry_t head_entry;

    // empty only feeds the pointer block's own checks
    rob_ptr_ctrl #(.ROB_DEPTH(ROB_DEPTH)) u_ptr (
        .clk         (clk),
        .rst_n       (rst_n),
        .alloc_valid (alloc_valid),
        .alloc_block (alloc_block),
        .pop         (pop),
        .flush       (flush),
        .alloc_ack   (alloc_ack),
        .head        (head),
        .tail        (alloc_tag),
        .full        (full),
        .empty       ()
    );

    rob_entry_array #(.ROB_DEPTH(ROB_DEPTH)) u_entries (
        .clk            (clk),
        .rst_n          (rst_n),
        .alloc_we       (alloc_ack),
        .alloc_tag      (alloc_tag),
        .alloc          (alloc),
        .complete_valid (complete_valid),
        .complete       (complete),
        .head           (head),
        .pop            (pop),
        .flush          (flush),
        .head_entry     (head_entry),
        .head_valid     (head_valid)
    );

    rob_commit_fsm u_commit (
        .clk                 (clk),
        .rst_n               (rst_n),
        .head                (head),
        .head_valid          (head_valid),
        .head_entry          (head_entry),
        .store_ack           (store_ack),
        .pop                 (pop),
        .flush               (flush),
        .alloc_block         (alloc_block),
        .retire_valid        (retire_valid),
        .retire              (retire),
        .store_release_valid (store_release_valid),
        .store_tag           (store_tag),
        .redirect_valid      (redirect_valid),
        .redirect_pc         (redirect_pc)
    );

endmodule

`default_nettype wire

// ==== source/rob_types_pkg.sv ====
`default_nettype none

package rob_types_pkg;

    // reorder buffer entry number, wide enough for a depth of 32
    typedef logic [4:0] tag_t;

    // architectural register number
    typedef logic [4:0] reg_name_t;

    // result value
    typedef logic [31:0] data_t;

    // instruction address
    typedef logic [31:0] addr_t;

    // retire state machine
    typedef enum logic [1:0] {
        ST_RUN        = 2'd0,
        ST_STORE_WAIT = 2'd1,
        ST_FLUSH      = 2'd2
    } rob_state_t;

endpackage

`default_nettype wire

// ==== include/rob_tb_tests.svh ====
`ifndef ROB_TB_TESTS_SVH
`define ROB_TB_TESTS_SVH

    // decode side, rd and the later result value come from the LFSR
    task automatic alloc_entry(input logic is_store, input logic pred_taken,
                               output rob_retire_t rec);
        rob_alloc_t  a;
        logic [31:0] bits;
        int          waited;
        take_bits(5, bits);
        a.rd         = bits[4:0];
        a.is_store   = is_store;
        a.pred_taken = pred_taken;
        take_bits(32, bits);
        rec.tag  = tb_tail;
        rec.rd   = a.rd;
        rec.data = bits;
        waited   = 0;
        @(posedge clk);
        alloc_valid <= 1'b1;
        alloc_in    <= a;
        @(negedge clk);
        while (!alloc_ack) begin
            if (waited == OP_BOUND) begin
                report_timeout("alloc_ack");
            end
            waited++;
            @(negedge clk);
        end
        check_value("alloc_tag", 32'(alloc_tag), 32'(rec.tag));
        @(posedge clk);
        alloc_valid <= 1'b0;
        model_q.push_back(rec);
        tb_tail = tag_t'((int'(tb_tail) + 1) % ROB_DEPTH);
    endtask

    task automatic complete_entry(input rob_retire_t rec, input logic taken,
                                  input addr_t target);
        rob_complete_t c;
        c.tag          = rec.tag;
        c.data         = rec.data;
        c.actual_taken = taken;
        c.target       = target;
        @(posedge clk);
        complete_valid <= 1'b1;
        complete_in    <= c;
        @(posedge clk);
        complete_valid <= 1'b0;
    endtask

    task automatic expect_retires(input int n);
        rob_retire_t exp;
        rob_retire_t got;
        int          i;
        wait_events("retire_valid", EV_RETIRE, retired_rd + n);
        for (i = 0; i < n; i++) begin
            exp = model_q.pop_front();
            got = retired_q[retired_rd];
            retired_rd++;
            check_value("retire.tag", 32'(got.tag), 32'(exp.tag));
            check_value("retire.rd", 32'(got.rd), 32'(exp.rd));
            check_value("retire.data", got.data, exp.data);
        end
    endtask

    task automatic refuse_alloc(input int cycles);
        int i;
        @(posedge clk);
        alloc_valid <= 1'b1;
        for (i = 0; i < cycles; i++) begin
            @(negedge clk);
            check_value("full", 32'(full), 32'd1);
            check_value("alloc_ack", 32'(alloc_ack), 32'd0);
        end
        @(posedge clk);
        alloc_valid <= 1'b0;
    endtask

    task automatic reset_defaults();
        @(negedge clk);
        check_value("full", 32'(full), 32'd0);
        check_value("alloc_ack", 32'(alloc_ack), 32'd0);
        check_value("retire_valid", 32'(retire_valid), 32'd0);
        check_value("store_release_valid", 32'(store_release_valid), 32'd0);
        check_value("redirect_valid", 32'(redirect_valid), 32'd0);
        check_value("alloc_tag", 32'(alloc_tag), 32'd0);
    endtask

    task automatic retire_in_order();
        rob_retire_t recs[6];
        int          order[6];
        logic [31:0] bits;
        int          i;
        int          j;
        int          tmp;
        for (i = 0; i < 6; i++) begin
            alloc_entry(1'b0, 1'b0, recs[i]);
            order[i] = i;
        end
        // shuffled completion order
        for (i = 5; i > 0; i--) begin
            take_bits(3, bits);
            j        = int'(bits % 32'(i + 1));
            tmp      = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        for (i = 0; i < 6; i++) begin
            complete_entry(recs[order[i]], 1'b0, '0);
        end
        expect_retires(6);
        idle_cycles(3);
        check_value("retire count", 32'(retired_q.size()), 32'(retired_rd));
    endtask

    task automatic fill_and_refuse();
        rob_retire_t recs[ROB_DEPTH + 1];
        int          i;
        for (i = 0; i < ROB_DEPTH; i++) begin
            alloc_entry(1'b0, 1'b0, recs[i]);
        end
        refuse_alloc(3);
        complete_entry(recs[0], 1'b0, '0);
        expect_retires(1);
        // one slot freed, the tail wraps onto it
        alloc_entry(1'b0, 1'b0, recs[ROB_DEPTH]);
        refuse_alloc(2);
        for (i = 1; i <= ROB_DEPTH; i++) begin
            complete_entry(recs[i], 1'b0, '0);
        end
        expect_retires(ROB_DEPTH);
    endtask

    task automatic store_release_wait();
        rob_retire_t st;
        rob_retire_t younger[2];
        alloc_entry(1'b1, 1'b0, st);
        alloc_entry(1'b0, 1'b0, younger[0]);
        alloc_entry(1'b0, 1'b0, younger[1]);
        complete_entry(younger[0], 1'b0, '0);
        complete_entry(younger[1], 1'b0, '0);
        complete_entry(st, 1'b0, '0);
        wait_events("store_release_valid", EV_RELEASE, 1);
        check_value("store_tag", 32'(released_tag), 32'(st.tag));
        // younger entries are done but stay behind the store
        idle_cycles(5);
        check_value("retire count", 32'(retired_q.size()), 32'(retired_rd));
        check_value("store_release count", release_cnt, 1);
        @(posedge clk);
        store_ack <= 1'b1;
        @(posedge clk);
        store_ack <= 1'b0;
        model_q.delete(0);
        expect_retires(2);
    endtask

    task automatic mispredict_flush();
        rob_retire_t br;
        rob_retire_t younger[2];
        rob_retire_t fresh;
        logic [31:0] bits;
        addr_t       target;
        take_bits(30, bits);
        target = {bits[29:0], 2'b00};
        alloc_entry(1'b0, 1'b0, br);
        alloc_entry(1'b0, 1'b0, younger[0]);
        alloc_entry(1'b0, 1'b0, younger[1]);
        complete_entry(younger[0], 1'b0, '0);
        complete_entry(younger[1], 1'b0, '0);
        complete_entry(br, 1'b1, target);
        wait_events("redirect_valid", EV_REDIRECT, 1);
        check_value("redirect_pc", redirected_pc, target);
        // the branch retire shares the redirect cycle
        check_value("retire count", 32'(retired_q.size()), 32'(retired_rd + 1));
        expect_retires(1);
        idle_cycles(3);
        check_value("retire count", 32'(retired_q.size()), 32'(retired_rd));
        check_value("redirect count", redirect_cnt, 1);
        model_q.delete();
        tb_tail = '0;
        alloc_entry(1'b0, 1'b0, fresh);
        complete_entry(fresh, 1'b0, '0);
        expect_retires(1);
    endtask

`endif

// ==== test/rob_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module rob_tb
    import rob_types_pkg::*;
    import rob_msg_pkg::*;
#(
    parameter int ROB_DEPTH = 8
) ();

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 10;
    // cycles allowed per handshake, and roughly how many operations the tests run
    localparam int OP_BOUND     = 20;
    localparam int TEST_OPS     = 64;
    localparam int EV_RETIRE    = 0;
    localparam int EV_RELEASE   = 1;
    localparam int EV_REDIRECT  = 2;

    logic          clk;
    logic          rst_n;
    logic          alloc_valid;
    rob_alloc_t    alloc_in;
    logic          alloc_ack;
    tag_t          alloc_tag;
    logic          full;
    logic          complete_valid;
    rob_complete_t complete_in;
    logic          store_ack;
    logic          retire_valid;
    rob_retire_t   retire;
    logic          store_release_valid;
    tag_t          store_tag;
    logic          redirect_valid;
    addr_t         redirect_pc;

    // pulses seen by the monitor
    rob_retire_t retired_q[$];
    int          retired_rd;
    int          release_cnt = 0;
    tag_t        released_tag;
    int          redirect_cnt = 0;
    addr_t       redirected_pc;

    // expected retire order and the tag decode should get next
    rob_retire_t model_q[$];
    tag_t        tb_tail;
    logic [15:0] lfsr_state;

    rob_top #(.ROB_DEPTH(ROB_DEPTH)) u_dut (
        .clk                 (clk),
        .rst_n               (rst_n),
        .alloc_valid         (alloc_valid),
        .alloc               (alloc_in),
        .alloc_ack           (alloc_ack),
        .alloc_tag           (alloc_tag),
        .full                (full),
        .complete_valid      (complete_valid),
        .complete            (complete_in),
        .store_ack           (store_ack),
        .retire_valid        (retire_valid),
        .retire              (retire),
        .store_release_valid (store_release_valid),
        .store_tag           (store_tag),
        .redirect_valid      (redirect_valid),
        .redirect_pc         (redirect_pc)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // watchdog
    initial begin
        #((TEST_OPS * OP_BOUND + RESET_CYCLES) * CLK_PERIOD);
        $display("watchdog expired before the tests finished");
        $display("RESULT: FAIL");
        $fatal(1);
    end

    // sampled mid-cycle, where the combinational pulses are settled
    always @(negedge clk) begin
        if (rst_n && retire_valid) begin
            retired_q.push_back(retire);
        end
        if (rst_n && store_release_valid) begin
            release_cnt++;
            released_tag = store_tag;
        end
        if (rst_n && redirect_valid) begin
            redirect_cnt++;
            redirected_pc = redirect_pc;
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display("RESULT: FAIL");
            $fatal(1);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timed out after %0d cycles waiting for %s", OP_BOUND, what);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    // galois form, taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 16'hB400;
        end
        return n;
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    function automatic int event_count(input int kind);
        case (kind)
            EV_RETIRE:  return retired_q.size();
            EV_RELEASE: return release_cnt;
            default:    return redirect_cnt;
        endcase
    endfunction

    task automatic wait_events(input string what, input int kind, input int total);
        int waited;
        waited = 0;
        while (event_count(kind) < total) begin
            if (waited == OP_BOUND) begin
                report_timeout(what);
            end
            waited++;
            @(posedge clk);
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    `include "rob_tb_tests.svh"

    initial begin
        lfsr_state = 16'd53317;
        tb_tail    = '0;
        retired_rd = 0;
        rst_n          <= 1'b0;
        alloc_valid    <= 1'b0;
        alloc_in       <= '0;
        complete_valid <= 1'b0;
        complete_in    <= '0;
        store_ack      <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        reset_defaults();
        retire_in_order();
        fill_and_refuse();
        store_release_wait();
        mispredict_flush();

        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire
